// File: all.f
+incdir+tb
rtl/ctrl_pkg.sv
rtl/ctrl_exc_decode.sv
rtl/ctrl_irq_arbiter.sv
rtl/ctrl_fsm.sv
rtl/ctrl_trap_result.sv
rtl/ctrl_top.sv
tb/tb_ctrl.sv

// File: tb/tb_ctrl_model.svh
////////////////////////////////////////////////////////////////////////////
// reference model for the controller testbench: xorshift generator,
// expected exception cause and mtval, interrupt take and cause rules
////////////////////////////////////////////////////////////////////////////

`ifndef TB_CTRL_MODEL_SVH
`define TB_CTRL_MODEL_SVH

// one xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// winning exception by priority, code 0 when nothing traps
task automatic model_exception(
  input  ctrl_pkg::id_instr_t  id,
  input  ctrl_pkg::dec_flags_t dec,
  input  ctrl_pkg::lsu_err_t   lsu,
  input  ctrl_pkg::csr_ctrl_t  csr,
  output logic [4:0]           code,
  output logic [31:0]          mtval
);
  logic in_m;
  logic illegal;
  in_m = (csr.priv == ctrl_pkg::PRIV_M);
  // mret outside M-mode and wfi trapped by tw count as illegal
  illegal = id.valid & (dec.illegal | (~in_m & (dec.mret | (csr.tw & dec.wfi))));
  code  = 5'd0;
  mtval = 32'h0;
  if (id.valid && id.fetch_err) begin
    code  = 5'd1;
    mtval = id.fetch_err_plus2 ? (id.pc + 32'd2) : id.pc;
  end else if (illegal) begin
    code  = 5'd2;
    mtval = id.is_compressed ? {16'h0, id.instr_c} : id.instr;
  end else if (id.valid && dec.ecall) begin
    code = in_m ? 5'd11 : 5'd8;
  end else if (id.valid && dec.ebrk) begin
    code = 5'd3;
  end else if (lsu.store_err) begin
    code  = 5'd7;
    mtval = lsu.addr_last;
  end else if (lsu.load_err) begin
    code  = 5'd5;
    mtval = lsu.addr_last;
  end
endtask

// any maskable line raised
function automatic logic irq_pending(input ctrl_pkg::irq_req_t irq);
  return irq.software | irq.timer | irq.external | (|irq.fast);
endfunction

// NMI mode blocks all, mie gates the maskable lines
function automatic logic irq_taken(input ctrl_pkg::irq_req_t irq, input logic mie,
                                   input logic nmi_mode);
  return ~nmi_mode & (irq.nm | (irq_pending(irq) & mie));
endfunction

// {is_irq, code}: NMI, highest fast line as 16 plus id, external, software, timer
function automatic logic [5:0] irq_cause(input ctrl_pkg::irq_req_t irq);
  logic [5:0] cause;
  cause = {1'b1, 5'd7};
  if (irq.nm) begin
    cause = {1'b1, 5'd31};
  end else if (|irq.fast) begin
    for (int i = 0; i < 15; i++) begin
      if (irq.fast[i]) begin
        cause = {2'b11, i[3:0]};
      end
    end
  end else if (irq.external) begin
    cause = {1'b1, 5'd11};
  end else if (irq.software) begin
    cause = {1'b1, 5'd3};
  end
  return cause;
endfunction

`endif

// File: tb/tb_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// controller testbench: clock, reset, random stimulus and checks for boot,
// exceptions, interrupts, mret, wfi sleep, branches and stalls
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_ctrl;

  `include "tb_ctrl_model.svh"

  logic                 clk_i;
  logic                 rst_ni;
  ctrl_pkg::id_instr_t  id_in;
  ctrl_pkg::dec_flags_t dec;
  ctrl_pkg::lsu_err_t   lsu;
  ctrl_pkg::irq_req_t   irq;
  ctrl_pkg::csr_ctrl_t  csr;
  logic                 stall_id, branch_set, jump_set;
  ctrl_pkg::if_ctrl_t   if_ctrl;
  ctrl_pkg::id_ctrl_t   id_ctrl;
  ctrl_pkg::trap_info_t trap;
  logic                 ctrl_busy, nmi_mode;
  logic [31:0]          rng_state;

  ctrl_top ctrl_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .id_i         (id_in),
    .dec_i        (dec),
    .lsu_i        (lsu),
    .irq_i        (irq),
    .csr_i        (csr),
    .stall_id_i   (stall_id),
    .branch_set_i (branch_set),
    .jump_set_i   (jump_set),
    .if_ctrl_o    (if_ctrl),
    .id_ctrl_o    (id_ctrl),
    .trap_o       (trap),
    .ctrl_busy_o  (ctrl_busy),
    .nmi_mode_o   (nmi_mode)
  );

  // 40 ns period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input logic ok, input string what);
    assert (ok) else fail_now($sformatf("ERR %0t: %s", $time, what));
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else
      fail_now($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  // inputs move 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic set_idle();
    id_in      = '0;
    dec        = '0;
    lsu        = '0;
    irq        = '0;
    csr.mie    = 1'b0;
    csr.tw     = 1'b0;
    csr.priv   = ctrl_pkg::PRIV_M;
    stall_id   = 1'b0;
    branch_set = 1'b0;
    jump_set   = 1'b0;
  endtask

  // outputs sampled at the falling edge, inputs stay held meanwhile
  task automatic wait_pc_set(input ctrl_pkg::pc_sel_e sel, input string what);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 50) begin
      @(negedge clk_i);
      seen = if_ctrl.pc_set && (if_ctrl.pc_mux == sel);
      n++;
    end
    if (!seen) fail_now($sformatf("timed out after 50 cycles waiting for pc_set in %s", what));
  endtask

  task automatic wait_busy(input logic level, input string what);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 50) begin
      @(negedge clk_i);
      seen = (ctrl_busy == level);
      n++;
    end
    if (!seen) fail_now($sformatf("timed out after 50 cycles waiting for busy in %s", what));
  endtask

  task automatic expect_quiet(input int cycles, input string what);
    repeat (cycles) begin
      @(negedge clk_i);
      check(!if_ctrl.pc_set, what);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // scenarios
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_exceptions(input int count);
    logic [4:0]  code;
    logic [31:0] mtval;
    logic [31:0] r;
    for (int k = 0; k < count; k++) begin
      next_cycle();
      r = rand32();
      id_in.valid           = 1'b1;
      id_in.instr           = rand32();
      id_in.instr_c         = r[15:0];
      id_in.is_compressed   = r[16];
      id_in.fetch_err       = (r[19:18] == 2'b00);
      id_in.fetch_err_plus2 = r[20];
      r = rand32();
      id_in.pc = {r[31:1], 1'b0};
      r = rand32();
      // sparse flags so every source gets its turn at winning
      dec.illegal    = (r[1:0] == 2'b00);
      dec.ecall      = (r[3:2] == 2'b00);
      dec.mret       = (r[5:4] == 2'b00);
      dec.wfi        = (r[7:6] == 2'b00);
      dec.ebrk       = (r[9:8] == 2'b00);
      dec.csr_flush  = (r[11:10] == 2'b00);
      lsu.load_err   = (r[14:12] == 3'b000);
      lsu.store_err  = (r[17:15] == 3'b000);
      csr.priv       = r[20] ? ctrl_pkg::PRIV_M : ctrl_pkg::PRIV_U;
      csr.tw         = r[21];
      csr.mie        = r[22];
      lsu.addr_last  = rand32();
      model_exception(id_in, dec, lsu, csr, code, mtval);
      // nothing traps, fall back on an ecall
      if (code == 5'd0) begin
        dec.ecall = 1'b1;
        model_exception(id_in, dec, lsu, csr, code, mtval);
      end
      wait_pc_set(ctrl_pkg::PC_EXC, "exception entry");
      check_val({26'h0, trap.cause}, {27'h0, code}, "exception cause");
      check_val(trap.mtval, mtval, "exception mtval");
      check(trap.save_id && trap.save_cause && !trap.save_if, "exception save strobes");
      next_cycle();
      set_idle();
    end
  endtask

  // M-mode mret, also the way out of NMI mode
  task automatic do_mret(input string what);
    next_cycle();
    id_in.valid = 1'b1;
    id_in.instr = rand32();
    dec.mret    = 1'b1;
    csr.priv    = ctrl_pkg::PRIV_M;
    wait_pc_set(ctrl_pkg::PC_ERET, what);
    check(trap.restore_mret && !trap.save_cause, "mret restore strobe");
    next_cycle();
    set_idle();
    check(!nmi_mode, "nmi mode cleared by mret");
  endtask

  task automatic run_interrupts(input int count);
    logic [31:0] r;
    logic [31:0] r2;
    logic [5:0]  cause;
    logic        was_nm;
    for (int k = 0; k < count; k++) begin
      next_cycle();
      r  = rand32();
      r2 = rand32();
      irq.nm       = (r[2:0] == 3'b000) || (k == 3);
      irq.software = r[3] & r[4];
      irq.timer    = r[5] & r[6];
      irq.external = r[7] & r[8];
      irq.fast     = r[23:9] & r2[14:0] & r2[29:15];
      csr.mie      = r[24];
      was_nm       = irq.nm;
      if (irq_taken(irq, csr.mie, 1'b0)) begin
        cause = irq_cause(irq);
        wait_pc_set(ctrl_pkg::PC_EXC, "interrupt entry");
        check_val({26'h0, trap.cause}, {26'h0, cause}, "interrupt cause");
        check(trap.save_if && trap.save_cause && !trap.save_id, "interrupt save strobes");
        next_cycle();
        set_idle();
        check(nmi_mode == was_nm, "nmi mode after interrupt entry");
        if (was_nm) begin
          // every line up and enabled, still nothing may be taken
          irq     = '1;
          csr.mie = 1'b1;
          expect_quiet(20, "no interrupt taken in NMI mode");
          next_cycle();
          set_idle();
          do_mret("NMI exit");
        end
      end else begin
        expect_quiet(50, "no pc_set with masked interrupts");
        next_cycle();
        set_idle();
      end
    end
  endtask

  task automatic run_wfi(input int count);
    logic [31:0] r;
    for (int k = 0; k < count; k++) begin
      next_cycle();
      r = rand32();
      id_in.valid = 1'b1;
      dec.wfi     = 1'b1;
      csr.priv    = ctrl_pkg::PRIV_M;
      csr.tw      = r[0];
      wait_busy(1'b0, "wfi sleep entry");
      next_cycle();
      set_idle();
      repeat (10) begin
        @(negedge clk_i);
        check(!ctrl_busy, "busy stays low while asleep");
      end
      next_cycle();
      // wake does not need mie
      case (r[2:1])
        2'd0: irq.software = 1'b1;
        2'd1: irq.timer = 1'b1;
        2'd2: irq.external = 1'b1;
        default: irq.fast[r[6:3] % 15] = 1'b1;
      endcase
      wait_busy(1'b1, "wake from wfi");
      next_cycle();
      set_idle();
    end
  endtask

  task automatic run_branches(input int count);
    logic [31:0] r;
    for (int k = 0; k < count; k++) begin
      next_cycle();
      r = rand32();
      id_in.valid = 1'b1;
      id_in.instr = rand32();
      stall_id    = r[0];
      branch_set  = r[1];
      jump_set    = r[2] & ~r[1];
      @(negedge clk_i);
      check(if_ctrl.pc_set == (branch_set | jump_set), "pc_set follows branch or jump");
      if (if_ctrl.pc_set) begin
        check(if_ctrl.pc_mux == ctrl_pkg::PC_JUMP, "redirect selects the jump target");
      end
      check(id_ctrl.id_in_ready == !stall_id, "id_in_ready against stall");
      check(!(stall_id && id_ctrl.instr_valid_clear), "no valid clear under stall");
    end
    next_cycle();
    set_idle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rng_state = 32'hbe8ab68c;
    rst_ni    = 1'b0;
    set_idle();
    repeat (8) begin
      @(negedge clk_i);
      check(!if_ctrl.instr_req, "no fetch during reset");
      check(if_ctrl.pc_mux == ctrl_pkg::PC_BOOT, "boot select during reset");
      check(!trap.save_if && !trap.save_id && !trap.restore_mret, "no strobes during reset");
      check(!nmi_mode && !id_ctrl.id_in_ready && !id_ctrl.flush_id, "idle ID during reset");
    end
    next_cycle();
    rst_ni = 1'b1;
    // boot address set in the first two cycles
    @(negedge clk_i);
    check(if_ctrl.pc_set && if_ctrl.pc_mux == ctrl_pkg::PC_BOOT && ctrl_busy, "boot cycle 1");
    check(!if_ctrl.instr_req, "no fetch in first boot cycle");
    @(negedge clk_i);
    check(if_ctrl.pc_set && if_ctrl.pc_mux == ctrl_pkg::PC_BOOT && ctrl_busy, "boot cycle 2");
    @(negedge clk_i);
    check(!if_ctrl.pc_set && if_ctrl.instr_req, "first fetch after boot");
    next_cycle();
    run_exceptions(40);
    run_interrupts(30);
    do_mret("plain mret");
    run_wfi(3);
    run_branches(30);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/ctrl_top.sv
////////////////////////////////////////////////////////////////////////////
// controller top: decode, irq arbiter, FSM and trap result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ctrl_pkg::id_instr_t  id_i,
  input  ctrl_pkg::dec_flags_t dec_i,
  input  ctrl_pkg::lsu_err_t   lsu_i,
  input  ctrl_pkg::irq_req_t   irq_i,
  input  ctrl_pkg::csr_ctrl_t  csr_i,
  input  logic                 stall_id_i,
  input  logic                 branch_set_i,
  input  logic                 jump_set_i,
  output ctrl_pkg::if_ctrl_t   if_ctrl_o,
  output ctrl_pkg::id_ctrl_t   id_ctrl_o,
  output ctrl_pkg::trap_info_t trap_o,
  output logic                 ctrl_busy_o,
  output logic                 nmi_mode_o
);

  ctrl_pkg::ctrl_req_t  req;
  ctrl_pkg::exc_sel_t   exc_sel;
  ctrl_pkg::exc_cause_u irq_cause;
  logic                 in_flush, handle_irq, is_nmi, wake;
  logic                 take_exc, take_irq, take_mret;

  ctrl_exc_decode u_exc_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .id_i       (id_i),
    .dec_i      (dec_i),
    .lsu_i      (lsu_i),
    .csr_i      (csr_i),
    .in_flush_i (in_flush),
    .req_o      (req),
    .exc_sel_o  (exc_sel)
  );

  ctrl_irq_arbiter u_irq_arbiter (
    .irq_i        (irq_i),
    .mie_i        (csr_i.mie),
    .nmi_mode_i   (nmi_mode_o),
    .handle_irq_o (handle_irq),
    .wake_o       (wake),
    .is_nmi_o     (is_nmi),
    .irq_cause_o  (irq_cause)
  );

  ctrl_fsm u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req),
    .handle_irq_i  (handle_irq),
    .is_nmi_i      (is_nmi),
    .wake_i        (wake),
    .stall_id_i    (stall_id_i),
    .branch_set_i  (branch_set_i),
    .jump_set_i    (jump_set_i),
    .instr_valid_i (id_i.valid),
    .in_flush_o    (in_flush),
    .take_exc_o    (take_exc),
    .take_irq_o    (take_irq),
    .take_mret_o   (take_mret),
    .nmi_mode_o    (nmi_mode_o),
    .if_ctrl_o     (if_ctrl_o),
    .id_ctrl_o     (id_ctrl_o),
    .ctrl_busy_o   (ctrl_busy_o)
  );

  ctrl_trap_result u_trap_result (
    .take_exc_i  (take_exc),
    .take_irq_i  (take_irq),
    .take_mret_i (take_mret),
    .exc_sel_i   (exc_sel),
    .irq_cause_i (irq_cause),
    .id_i        (id_i),
    .lsu_addr_i  (lsu_i.addr_last),
    .priv_i      (csr_i.priv),
    .trap_o      (trap_o)
  );

endmodule

`default_nettype wire

// File: rtl/ctrl_trap_result.sv
////////////////////////////////////////////////////////////////////////////
// trap result: cause, mtval and CSR save strobes for a taken trap
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_trap_result (
  input  logic                            take_exc_i,
  input  logic                            take_irq_i,
  input  logic                            take_mret_i,
  input  ctrl_pkg::exc_sel_t              exc_sel_i,
  input  ctrl_pkg::exc_cause_u            irq_cause_i,
  input  ctrl_pkg::id_instr_t             id_i,
  input  logic [ctrl_pkg::xlen_w-1:0]     lsu_addr_i,
  input  ctrl_pkg::priv_lvl_e             priv_i,
  output ctrl_pkg::trap_info_t            trap_o
);

  // interrupts save the IF pc, exceptions the ID pc
  assign trap_o.save_if      = take_irq_i;
  assign trap_o.save_id      = take_exc_i;
  assign trap_o.save_cause   = take_exc_i | take_irq_i;
  assign trap_o.restore_mret = take_mret_i;

  always_comb begin
    trap_o.cause = '0;
    trap_o.mtval = '0;
    if (take_irq_i) begin
      trap_o.cause = irq_cause_i;
    end else if (take_exc_i) begin
      if (exc_sel_i.fetch_err) begin
        trap_o.cause.plain.code = ctrl_pkg::EXC_FETCH_FAULT;
        // fault may sit in the upper half of an unaligned word
        trap_o.mtval = id_i.fetch_err_plus2 ? (id_i.pc + ctrl_pkg::xlen_w'(2)) : id_i.pc;
      end else if (exc_sel_i.illegal) begin
        trap_o.cause.plain.code = ctrl_pkg::EXC_ILLEGAL;
        trap_o.mtval = id_i.is_compressed ?
                       {{(ctrl_pkg::xlen_w - ctrl_pkg::insn_c_w){1'b0}}, id_i.instr_c} :
                       id_i.instr;
      end else if (exc_sel_i.ecall) begin
        trap_o.cause.plain.code = (priv_i == ctrl_pkg::PRIV_M) ? ctrl_pkg::EXC_ECALL_M :
                                                                 ctrl_pkg::EXC_ECALL_U;
      end else if (exc_sel_i.ebrk) begin
        trap_o.cause.plain.code = ctrl_pkg::EXC_BREAKPOINT;
      end else if (exc_sel_i.store) begin
        trap_o.cause.plain.code = ctrl_pkg::EXC_STORE_FAULT;
        trap_o.mtval = lsu_addr_i;
      end else if (exc_sel_i.load) begin
        trap_o.cause.plain.code = ctrl_pkg::EXC_LOAD_FAULT;
        trap_o.mtval = lsu_addr_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ctrl_fsm.sv
////////////////////////////////////////////////////////////////////////////
// controller FSM: boot, decode, flush, interrupt entry and sleep,
// with halt, retain and flush control for the IF and ID stages
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ctrl_pkg::ctrl_req_t req_i,
  input  logic                handle_irq_i,
  input  logic                is_nmi_i,
  input  logic                wake_i,
  input  logic                stall_id_i,
  input  logic                branch_set_i,
  input  logic                jump_set_i,
  input  logic                instr_valid_i,
  output logic                in_flush_o,
  output logic                take_exc_o,
  output logic                take_irq_o,
  output logic                take_mret_o,
  output logic                nmi_mode_o,
  output ctrl_pkg::if_ctrl_t  if_ctrl_o,
  output ctrl_pkg::id_ctrl_t  id_ctrl_o,
  output logic                ctrl_busy_o
);

  ctrl_pkg::ctrl_state_e state_q, state_d;
  ctrl_pkg::pc_sel_e     pc_mux;
  logic                  nmi_mode_q, nmi_mode_d;
  logic                  instr_req, pc_set;
  logic                  halt_if, retain_id, flush_id;

  always_comb begin
    state_d     = state_q;
    nmi_mode_d  = nmi_mode_q;
    instr_req   = 1'b1;
    pc_set      = 1'b0;
    pc_mux      = ctrl_pkg::PC_BOOT;
    halt_if     = 1'b0;
    retain_id   = 1'b0;
    flush_id    = 1'b0;
    ctrl_busy_o = 1'b1;
    take_exc_o  = 1'b0;
    take_irq_o  = 1'b0;
    take_mret_o = 1'b0;

    unique case (state_q)
      ctrl_pkg::RESET: begin
        // no fetch yet, load boot address
        instr_req = 1'b0;
        pc_set    = 1'b1;
        halt_if   = 1'b1;
        state_d   = ctrl_pkg::BOOT_SET;
      end
      ctrl_pkg::BOOT_SET: begin
        pc_set  = 1'b1;
        halt_if = 1'b1;
        state_d = ctrl_pkg::FIRST_FETCH;
      end
      ctrl_pkg::WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req   = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = ctrl_pkg::SLEEP;
      end
      ctrl_pkg::SLEEP: begin
        instr_req = 1'b0;
        halt_if   = 1'b1;
        flush_id  = 1'b1;
        if (wake_i) begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end else begin
          // keep the clock gated
          ctrl_busy_o = 1'b0;
        end
      end
      ctrl_pkg::FIRST_FETCH: begin
        // wait out an IF miss
        if (id_ctrl_o.id_in_ready) begin
          state_d = ctrl_pkg::DECODE;
        end
        if (handle_irq_i) begin
          state_d = ctrl_pkg::IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end
      ctrl_pkg::DECODE: begin
        pc_mux = ctrl_pkg::PC_JUMP;
        // keep the instruction in ID so FLUSH can act on it
        if (req_i.special_req) begin
          retain_id = 1'b1;
          state_d   = ctrl_pkg::FLUSH;
        end
        // redirects go out even under a stall
        if (branch_set_i || jump_set_i) begin
          pc_set = 1'b1;
        end
        // an interrupt waits for the instruction in ID to finish
        if (handle_irq_i && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end
        if (!stall_id_i && !req_i.special_req && !instr_valid_i && handle_irq_i) begin
          state_d = ctrl_pkg::IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end
      ctrl_pkg::IRQ_TAKEN: begin
        pc_mux = ctrl_pkg::PC_EXC;
        if (handle_irq_i) begin
          pc_set     = 1'b1;
          take_irq_o = 1'b1;
          if (is_nmi_i) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = ctrl_pkg::DECODE;
      end
      ctrl_pkg::FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = ctrl_pkg::DECODE;
        if (req_i.exc_pending) begin
          pc_set     = 1'b1;
          pc_mux     = ctrl_pkg::PC_EXC;
          take_exc_o = 1'b1;
        end else if (req_i.mret) begin
          pc_set      = 1'b1;
          pc_mux      = ctrl_pkg::PC_ERET;
          take_mret_o = 1'b1;
          // returning from the NMI handler
          nmi_mode_d  = 1'b0;
        end else if (req_i.wfi) begin
          state_d = ctrl_pkg::WAIT_SLEEP;
        end else if (req_i.csr_flush && handle_irq_i) begin
          // CSR write may have enabled an interrupt
          state_d = ctrl_pkg::IRQ_TAKEN;
        end
      end
      default: begin
        instr_req = 1'b0;
        state_d   = ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ctrl_pkg::RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

  assign in_flush_o = (state_q == ctrl_pkg::FLUSH);
  assign nmi_mode_o = nmi_mode_q;

  assign if_ctrl_o.instr_req = instr_req;
  assign if_ctrl_o.pc_set    = pc_set;
  assign if_ctrl_o.pc_mux    = pc_mux;

  // retain_id holds valid in ID; flush_id still wins over it
  assign id_ctrl_o.id_in_ready       = ~stall_id_i & ~halt_if & ~retain_id;
  assign id_ctrl_o.instr_valid_clear = ~(stall_id_i | retain_id) | flush_id;
  assign id_ctrl_o.flush_id          = flush_id;

endmodule

`default_nettype wire

// File: rtl/ctrl_irq_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// interrupt arbiter: take decision, wake level and cause encoding
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_irq_arbiter (
  input  ctrl_pkg::irq_req_t   irq_i,
  input  logic                 mie_i,
  input  logic                 nmi_mode_i,
  output logic                 handle_irq_o,
  output logic                 wake_o,
  output logic                 is_nmi_o,
  output ctrl_pkg::exc_cause_u irq_cause_o
);

  logic                           any_pending;
  logic [ctrl_pkg::fast_id_w-1:0] fast_id;

  assign any_pending = irq_i.software | irq_i.timer | irq_i.external | (|irq_i.fast);

  // nested NMIs unsupported, NMI mode blocks everything
  assign handle_irq_o = ~nmi_mode_i & (irq_i.nm | (any_pending & mie_i));
  // sleep ends on any request, enabled or not
  assign wake_o       = irq_i.nm | any_pending;
  assign is_nmi_o     = irq_i.nm & ~nmi_mode_i;

  // highest fast id wins, later iterations override
  always_comb begin
    fast_id = '0;
    for (int i = 0; i < ctrl_pkg::fast_irq_n; i++) begin
      if (irq_i.fast[i]) begin
        fast_id = ctrl_pkg::fast_id_w'(i);
      end
    end
  end

  // order: NMI, fast, external, software, timer
  always_comb begin
    irq_cause_o              = '0;
    irq_cause_o.plain.is_irq = 1'b1;
    if (irq_i.nm) begin
      irq_cause_o.plain.code = ctrl_pkg::IRQ_NM;
    end else if (|irq_i.fast) begin
      irq_cause_o.fast.is_fast = 1'b1;
      irq_cause_o.fast.fast_id = fast_id;
    end else if (irq_i.external) begin
      irq_cause_o.plain.code = ctrl_pkg::irq_external_c;
    end else if (irq_i.software) begin
      irq_cause_o.plain.code = ctrl_pkg::irq_software_c;
    end else begin
      irq_cause_o.plain.code = ctrl_pkg::irq_timer_c;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ctrl_exc_decode.sv
////////////////////////////////////////////////////////////////////////////
// decode stage: qualifies decoder flags, flops exception requests and
// ranks the exception sources
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_exc_decode (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  ctrl_pkg::id_instr_t    id_i,
  input  ctrl_pkg::dec_flags_t   dec_i,
  input  ctrl_pkg::lsu_err_t     lsu_i,
  input  ctrl_pkg::csr_ctrl_t    csr_i,
  input  logic                   in_flush_i,
  output ctrl_pkg::ctrl_req_t    req_o,
  output ctrl_pkg::exc_sel_t     exc_sel_o
);

  logic ecall, mret, wfi, ebrk, csr_flush, fetch_err;
  logic illegal_umode;
  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_q, store_err_q;
  logic lsu_err;

  // decoder flags ignore valid, qualify them here
  assign ecall     = dec_i.ecall     & id_i.valid;
  assign mret      = dec_i.mret      & id_i.valid;
  assign wfi       = dec_i.wfi       & id_i.valid;
  assign ebrk      = dec_i.ebrk      & id_i.valid;
  assign csr_flush = dec_i.csr_flush & id_i.valid;
  assign fetch_err = id_i.fetch_err  & id_i.valid;

  // mret needs M-mode, and tw traps wfi outside M-mode
  assign illegal_umode = (csr_i.priv != ctrl_pkg::PRIV_M) & (mret | (csr_i.tw & wfi));

  // requests clear in FLUSH so a handled exception does not fire twice
  assign illegal_d = ((dec_i.illegal & id_i.valid) | illegal_umode) & ~in_flush_i;
  assign exc_req_d = (ecall | ebrk | illegal_d | fetch_err) & ~in_flush_i;

  // LSU errors arrive for one cycle only and bypass valid
  assign lsu_err = lsu_i.load_err | lsu_i.store_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= lsu_i.load_err  & ~in_flush_i;
      store_err_q <= lsu_i.store_err & ~in_flush_i;
    end
  end

  assign req_o.mret        = mret;
  assign req_o.wfi         = wfi;
  assign req_o.csr_flush   = csr_flush;
  assign req_o.special_req = mret | wfi | csr_flush | exc_req_d | lsu_err;
  assign req_o.exc_pending = exc_req_q | load_err_q | store_err_q;

  // priority: fetch fault, illegal, ecall, ebreak, store, load
  // only meaningful in FLUSH
  always_comb begin
    exc_sel_o = '0;
    if (in_flush_i) begin
      if (fetch_err) begin
        exc_sel_o.fetch_err = 1'b1;
      end else if (illegal_q) begin
        exc_sel_o.illegal = 1'b1;
      end else if (ecall) begin
        exc_sel_o.ecall = 1'b1;
      end else if (ebrk) begin
        exc_sel_o.ebrk = 1'b1;
      end else if (store_err_q) begin
        exc_sel_o.store = 1'b1;
      end else if (load_err_q) begin
        exc_sel_o.load = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// controller package: widths, FSM states, cause codes and the mcause
// union, plus the packed port structs shared by the controller modules
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package ctrl_pkg;

  // data and address width
  localparam int unsigned xlen_w       = 32;
  // compressed instruction width
  localparam int unsigned insn_c_w     = 16;
  localparam int unsigned fast_irq_n   = 15;
  localparam int unsigned fast_id_w    = 4;
  localparam int unsigned cause_code_w = 5;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // fetch address selector
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  // exception codes, plus NMI which has a code of its own
  typedef enum logic [cause_code_w-1:0] {
    EXC_FETCH_FAULT = 5'd1,
    EXC_ILLEGAL     = 5'd2,
    EXC_BREAKPOINT  = 5'd3,
    EXC_LOAD_FAULT  = 5'd5,
    EXC_STORE_FAULT = 5'd7,
    EXC_ECALL_U     = 5'd8,
    EXC_ECALL_M     = 5'd11,
    IRQ_NM          = 5'd31
  } exc_code_e;

  // standard interrupt codes overlap exception codes, so they sit outside the enum
  localparam logic [cause_code_w-1:0] irq_software_c = 5'd3;
  localparam logic [cause_code_w-1:0] irq_timer_c    = 5'd7;
  localparam logic [cause_code_w-1:0] irq_external_c = 5'd11;

  // mcause word, plain view
  typedef struct packed {
    logic                    is_irq;
    logic [cause_code_w-1:0] code;
  } cause_plain_t;

  // mcause word, fast view: is_fast adds 16 to the fast id
  typedef struct packed {
    logic                 is_irq;
    logic                 is_fast;
    logic [fast_id_w-1:0] fast_id;
  } cause_fast_t;

  typedef union packed {
    cause_plain_t plain;
    cause_fast_t  fast;
  } exc_cause_u;

  // instruction held in ID
  typedef struct packed {
    logic                valid;
    logic [xlen_w-1:0]   instr;
    logic [insn_c_w-1:0] instr_c;
    logic                is_compressed;
    logic                fetch_err;
    logic                fetch_err_plus2;
    logic [xlen_w-1:0]   pc;
  } id_instr_t;

  // raw decoder flags, not qualified with valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic csr_flush;
  } dec_flags_t;

  typedef struct packed {
    logic              load_err;
    logic              store_err;
    logic [xlen_w-1:0] addr_last;
  } lsu_err_t;

  typedef struct packed {
    logic                  nm;
    logic                  software;
    logic                  timer;
    logic                  external;
    logic [fast_irq_n-1:0] fast;
  } irq_req_t;

  typedef struct packed {
    logic      mie;
    logic      tw;
    priv_lvl_e priv;
  } csr_ctrl_t;

  // one-hot winning exception
  typedef struct packed {
    logic fetch_err;
    logic illegal;
    logic ecall;
    logic ebrk;
    logic store;
    logic load;
  } exc_sel_t;

  // requests from decode to the FSM
  typedef struct packed {
    logic mret;
    logic wfi;
    logic csr_flush;
    logic special_req;
    logic exc_pending;
  } ctrl_req_t;

  typedef struct packed {
    logic    instr_req;
    logic    pc_set;
    pc_sel_e pc_mux;
  } if_ctrl_t;

  typedef struct packed {
    logic id_in_ready;
    logic instr_valid_clear;
    logic flush_id;
  } id_ctrl_t;

  typedef struct packed {
    logic              save_if;
    logic              save_id;
    logic              save_cause;
    logic              restore_mret;
    exc_cause_u        cause;
    logic [xlen_w-1:0] mtval;
  } trap_info_t;

endpackage

`default_nettype wire
